// File: hdl/cache_pkg.sv
// shared widths for a word-addressed hierarchy: 30-bit word, 28-bit line addresses, no byte lanes
package cache_pkg;

    // ------------------------------------------------------------------------
    // data and address widths
    // ------------------------------------------------------------------------
    localparam int WORD_BITS      = 32;
    localparam int WORD_ADDR_BITS = 30;
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_SEL_BITS  = 2;      // log2 of words per line
    localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;
    localparam int LINE_ADDR_BITS = WORD_ADDR_BITS - WORD_SEL_BITS;

    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;
    typedef logic [LINE_BITS-1:0]      line_t;      // also one memory beat
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

    // ------------------------------------------------------------------------
    // first level, one word per line
    // ------------------------------------------------------------------------
    localparam int L1_SETS     = 16;
    localparam int L1_SET_BITS = 4;
    localparam int L1_TAG_BITS = WORD_ADDR_BITS - L1_SET_BITS;

    typedef logic [L1_TAG_BITS-1:0] l1_tag_t;

    // ------------------------------------------------------------------------
    // second level, four words per line
    // ------------------------------------------------------------------------
    localparam int L2_SETS     = 32;
    localparam int L2_SET_BITS = 5;
    // tag sits above set and word-select bits
    localparam int L2_TAG_BITS = LINE_ADDR_BITS - L2_SET_BITS;

    typedef logic [L2_TAG_BITS-1:0] l2_tag_t;

endpackage

// File: hdl/cache_line_store.sv
// two-way store; lookup is combinational, fill and write land on the next edge, tag/data not reset
`timescale 1ns/1ps

module cache_line_store #(
    parameter type tag_t    = logic [25:0],
    parameter type data_t   = logic [31:0],
    parameter int  num_sets = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [$clog2(num_sets)-1:0] set_idx,
    input  tag_t                        lookup_tag,
    input  logic                        access,
    input  logic                        fill_en,
    input  logic                        fill_dirty,
    input  data_t                       fill_data,
    input  logic                        write_en,
    input  data_t                       write_data,
    output logic                        hit,
    output data_t                       hit_data,
    output logic                        victim_dirty,
    output tag_t                        victim_tag,
    output data_t                       victim_data
);

    // ------------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------------
    tag_t  tag_mem  [2][num_sets];
    data_t data_mem [2][num_sets];

    logic [1:0][num_sets-1:0] valid_q;
    logic [1:0][num_sets-1:0] dirty_q;
    logic [num_sets-1:0]      lru_q;        // way to evict next

    logic hit_w0;
    logic hit_w1;
    logic hit_way;
    logic victim_way;

    // ------------------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------------------
    assign hit_w0  = valid_q[0][set_idx] && (tag_mem[0][set_idx] == lookup_tag);
    assign hit_w1  = valid_q[1][set_idx] && (tag_mem[1][set_idx] == lookup_tag);
    assign hit     = hit_w0 || hit_w1;
    assign hit_way = hit_w1;                // ways never hold the same tag

    assign hit_data = hit_way ? data_mem[1][set_idx] : data_mem[0][set_idx];

    assign victim_way   = lru_q[set_idx];
    assign victim_dirty = valid_q[victim_way][set_idx] && dirty_q[victim_way][set_idx];
    assign victim_tag   = tag_mem[victim_way][set_idx];
    assign victim_data  = data_mem[victim_way][set_idx];

    // ------------------------------------------------------------------------
    // state bits
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (fill_en) begin
                valid_q[victim_way][set_idx] <= 1'b1;
                dirty_q[victim_way][set_idx] <= fill_dirty;
            end else if (write_en && hit) begin
                dirty_q[hit_way][set_idx] <= 1'b1;
            end
            // the other way becomes the next victim
            if (access && hit)
                lru_q[set_idx] <= ~hit_way;
        end
    end

    // tag and payload
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[victim_way][set_idx]  <= lookup_tag;
            data_mem[victim_way][set_idx] <= fill_data;
        end else if (write_en && hit) begin
            data_mem[hit_way][set_idx] <= write_data;   // whole line or word
        end
    end

    // a fill only happens on a miss, a write only on a hit
    a_fill_write_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(fill_en && write_en)
    ) else $error("fill and write hit requested in the same cycle");

endmodule

// File: hdl/cache_miss_fsm.sv
// one miss at a time; the request must be held unchanged until the refill completes
`timescale 1ns/1ps

module cache_miss_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic req_read,
    input  logic req_write,
    input  logic hit,
    input  logic victim_dirty,
    input  logic mem_ready,
    output logic mem_read,
    output logic mem_write,
    output logic writeback_phase,
    output logic fill_en,
    output logic fill_dirty
);

    typedef enum logic [2:0] {
        s_idle,
        s_wb_rd,        // write back victim, then refill for a read
        s_rd,
        s_wb_wr,        // write back victim, then refill for a write
        s_rd_wr
    } miss_state_t;

    miss_state_t state_q;
    miss_state_t state_d;
    logic        miss;
    logic        refill_phase;

    assign miss = (req_read || req_write) && !hit;

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            s_idle: begin
                if (miss && req_write)
                    state_d = victim_dirty ? s_wb_wr : s_rd_wr;
                else if (miss)
                    state_d = victim_dirty ? s_wb_rd : s_rd;
            end
            s_wb_rd: if (mem_ready) state_d = s_rd;
            s_rd:    if (mem_ready) state_d = s_idle;
            s_wb_wr: if (mem_ready) state_d = s_rd_wr;
            s_rd_wr: if (mem_ready) state_d = s_idle;
            default: state_d = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            state_q <= s_idle;
        else
            state_q <= state_d;
    end

    // levels decoded from the registered state, so they start a cycle after the miss
    assign writeback_phase = (state_q == s_wb_rd) || (state_q == s_wb_wr);
    assign refill_phase    = (state_q == s_rd) || (state_q == s_rd_wr);
    assign mem_write       = writeback_phase;
    assign mem_read        = refill_phase;
    assign fill_en         = refill_phase && mem_ready;    // line arrives in this cycle
    assign fill_dirty      = (state_q == s_rd_wr);

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(mem_read && mem_write)
    ) else $error("memory read and write levels high together");

endmodule

// File: hdl/l1_cache.sv
// word-line L1; requester holds read/write, address and data while stall is high
`timescale 1ns/1ps

module l1_cache (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  proc_read,
    input  logic                  proc_write,
    input  cache_pkg::word_addr_t proc_addr,
    input  cache_pkg::word_t      proc_wdata,
    output cache_pkg::word_t      proc_rdata,
    output logic                  proc_stall,
    input  cache_pkg::word_t      mem_rdata,
    input  logic                  mem_ready,
    output logic                  mem_read,
    output logic                  mem_write,
    output cache_pkg::word_addr_t mem_addr,
    output cache_pkg::word_t      mem_wdata
);

    import cache_pkg::*;

    logic [L1_SET_BITS-1:0] set_idx;
    l1_tag_t                req_tag;
    l1_tag_t                victim_tag;
    logic                   access;
    logic                   hit;
    logic                   victim_dirty;
    logic                   writeback_phase;
    logic                   fill_en;
    logic                   fill_dirty;

    assign set_idx    = proc_addr[L1_SET_BITS-1:0];
    assign req_tag    = proc_addr[WORD_ADDR_BITS-1:L1_SET_BITS];
    assign access     = proc_read || proc_write;
    assign proc_stall = access && !hit;

    // victim address rebuilt from its own tag, not the request
    assign mem_addr = writeback_phase ? {victim_tag, set_idx} : proc_addr;

    cache_line_store #(
        .tag_t    (l1_tag_t),
        .data_t   (word_t),
        .num_sets (L1_SETS)
    ) u_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .set_idx      (set_idx),
        .lookup_tag   (req_tag),
        .access       (access),
        .fill_en      (fill_en),
        .fill_dirty   (fill_dirty),
        .fill_data    (mem_rdata),
        .write_en     (proc_write && hit),     // whole word
        .write_data   (proc_wdata),
        .hit          (hit),
        .hit_data     (proc_rdata),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_data  (mem_wdata)
    );

    cache_miss_fsm u_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_read        (proc_read),
        .req_write       (proc_write),
        .hit             (hit),
        .victim_dirty    (victim_dirty),
        .mem_ready       (mem_ready),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .writeback_phase (writeback_phase),
        .fill_en         (fill_en),
        .fill_dirty      (fill_dirty)
    );

    a_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
            proc_stall |=> (proc_read == $past(proc_read)) && (proc_write == $past(proc_write))
                && $stable(proc_addr) && (!proc_write || $stable(proc_wdata))
    ) else $error("requester changed its request while stalled");

endmodule

// File: hdl/l2_cache.sv
// four-word-line L2 behind a word port; the word port must hold its request while stalled
`timescale 1ns/1ps

module l2_cache (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  proc_read,
    input  logic                  proc_write,
    input  cache_pkg::word_addr_t proc_addr,
    input  cache_pkg::word_t      proc_wdata,
    output cache_pkg::word_t      proc_rdata,
    output logic                  proc_stall,
    input  cache_pkg::line_t      mem_rdata,
    input  logic                  mem_ready,
    output logic                  mem_read,
    output logic                  mem_write,
    output cache_pkg::line_addr_t mem_addr,
    output cache_pkg::line_t      mem_wdata
);

    import cache_pkg::*;

    // ------------------------------------------------------------------------
    // address split: | tag | set | word |
    // ------------------------------------------------------------------------
    logic [WORD_SEL_BITS-1:0] word_sel;
    logic [L2_SET_BITS-1:0]   set_idx;
    l2_tag_t                  req_tag;
    line_addr_t               line_addr;

    assign word_sel  = proc_addr[WORD_SEL_BITS-1:0];
    assign set_idx   = proc_addr[WORD_SEL_BITS +: L2_SET_BITS];
    assign req_tag   = proc_addr[WORD_ADDR_BITS-1 -: L2_TAG_BITS];
    assign line_addr = proc_addr[WORD_ADDR_BITS-1:WORD_SEL_BITS];

    l2_tag_t victim_tag;
    line_t   hit_line;
    line_t   merged_line;
    logic    access;
    logic    hit;
    logic    victim_dirty;
    logic    writeback_phase;
    logic    fill_en;
    logic    fill_dirty;

    assign access     = proc_read || proc_write;
    assign proc_stall = access && !hit;
    assign proc_rdata = hit_line[word_sel*WORD_BITS +: WORD_BITS];

    // write hit replaces one word, rest of the line kept
    always_comb begin
        merged_line = hit_line;
        merged_line[word_sel*WORD_BITS +: WORD_BITS] = proc_wdata;
    end

    assign mem_addr = writeback_phase ? {victim_tag, set_idx} : line_addr;

    cache_line_store #(
        .tag_t    (l2_tag_t),
        .data_t   (line_t),
        .num_sets (L2_SETS)
    ) u_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .set_idx      (set_idx),
        .lookup_tag   (req_tag),
        .access       (access),
        .fill_en      (fill_en),
        .fill_dirty   (fill_dirty),
        .fill_data    (mem_rdata),
        .write_en     (proc_write && hit),
        .write_data   (merged_line),
        .hit          (hit),
        .hit_data     (hit_line),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_data  (mem_wdata)
    );

    cache_miss_fsm u_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_read        (proc_read),
        .req_write       (proc_write),
        .hit             (hit),
        .victim_dirty    (victim_dirty),
        .mem_ready       (mem_ready),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .writeback_phase (writeback_phase),
        .fill_en         (fill_en),
        .fill_dirty      (fill_dirty)
    );

endmodule

// File: hdl/mem_hier_top.sv
// data-side L1 plus L2 over a line-wide memory; one outstanding access, request held while stalled
`timescale 1ns/1ps

module mem_hier_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  proc_read,
    input  logic                  proc_write,
    input  cache_pkg::word_addr_t proc_addr,
    input  cache_pkg::word_t      proc_wdata,
    output cache_pkg::word_t      proc_rdata,
    output logic                  proc_stall,
    output logic                  mem_read,
    output logic                  mem_write,
    output cache_pkg::line_addr_t mem_addr,
    output cache_pkg::line_t      mem_wdata,
    input  cache_pkg::line_t      mem_rdata,
    input  logic                  mem_ready
);

    import cache_pkg::*;

    // ------------------------------------------------------------------------
    // L1 to L2 word link
    // ------------------------------------------------------------------------
    logic       l1_read;
    logic       l1_write;
    word_addr_t l1_addr;
    word_t      l1_wdata;
    word_t      l1_rdata;
    logic       l2_stall;
    logic       l1_ready;

    assign l1_ready = ~l2_stall;    // L2 completes in its non-stalled cycle

    l1_cache u_l1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_rdata  (l1_rdata),
        .mem_ready  (l1_ready),
        .mem_read   (l1_read),
        .mem_write  (l1_write),
        .mem_addr   (l1_addr),
        .mem_wdata  (l1_wdata)
    );

    l2_cache u_l2 (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_read  (l1_read),
        .proc_write (l1_write),
        .proc_addr  (l1_addr),
        .proc_wdata (l1_wdata),
        .proc_rdata (l1_rdata),
        .proc_stall (l2_stall),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

endmodule

// File: verif/slow_mem_model.sv
// line-wide memory; only the low address bits that fit depth_lines are decoded, one request at a time
`timescale 1ns/1ps

module slow_mem_model #(
    parameter int depth_lines = 1024,
    parameter int resp_delay  = 4       // cycles from request level to ready
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  cache_pkg::line_addr_t mem_addr,
    input  cache_pkg::line_t      mem_wdata,
    output cache_pkg::line_t      mem_rdata,
    output logic                  mem_ready
);

    import cache_pkg::*;

    localparam int idx_bits = $clog2(depth_lines);

    line_t mem [depth_lines];
    int    wait_cnt;

    logic [idx_bits-1:0] idx;

    assign idx       = mem_addr[idx_bits-1:0];
    assign mem_rdata = mem[idx];        // valid whenever ready is high

    // ------------------------------------------------------------------------
    // response timing and storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt  <= 0;
            mem_ready <= 1'b0;
            // word k of the window holds k xor 5a5a_0000
            for (int l = 0; l < depth_lines; l++) begin
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    mem[l][w*WORD_BITS +: WORD_BITS] <=
                        word_t'(l * WORDS_PER_LINE + w) ^ 32'h5A5A_0000;
                end
            end
        end else begin
            mem_ready <= 1'b0;
            if ((mem_read || mem_write) && !mem_ready) begin
                if (wait_cnt == resp_delay - 1) begin
                    mem_ready <= 1'b1;
                    wait_cnt  <= 0;
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end
            if (mem_ready && mem_write)
                mem[idx] <= mem_wdata;  // write lands in the ready cycle
        end
    end

endmodule

// File: verif/tb_mem_hier.sv
// testbench for mem_hier_top; requests stay inside a 4096-word window, one access at a time
`timescale 1ns/1ps

module tb_mem_hier;

    import cache_pkg::*;

    localparam int reset_cycles    = 10;
    localparam int window_words    = 4096;     // 1024 memory lines
    localparam int win_bits        = 12;
    localparam int n_directed      = 18;
    localparam int n_random        = 300;
    localparam int num_ops         = n_directed + n_random;
    localparam int max_stall       = 40;
    localparam int watchdog_cycles = num_ops * 40 + reset_cycles;
    localparam int conflict_base   = 'h013;    // same L1 and L2 set every 128 words

    logic       clk;
    logic       rst_n;
    logic       proc_read;
    logic       proc_write;
    word_addr_t proc_addr;
    word_t      proc_wdata;
    word_t      proc_rdata;
    logic       proc_stall;
    logic       mem_read;
    logic       mem_write;
    line_addr_t mem_addr;
    line_t      mem_wdata;
    line_t      mem_rdata;
    logic       mem_ready;

    word_t  shadow [window_words];
    word_t  exp_rdata;
    logic   expect_hit;
    logic   expect_miss;
    logic   access_done;
    int     stall_len;
    int     wb_count;
    int     value_errors;
    int     other_errors;
    integer seed;

    mem_hier_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    slow_mem_model #(
        .depth_lines (1024),
        .resp_delay  (4)
    ) u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    always #4 clk = ~clk;

    // ------------------------------------------------------------------------
    // cycle bookkeeping
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            access_done <= 1'b0;
            stall_len   <= 0;
            wb_count    <= 0;
        end else begin
            access_done <= (proc_read || proc_write) && !proc_stall;
            stall_len   <= proc_stall ? stall_len + 1 : 0;
            if (mem_write && mem_ready)
                wb_count <= wb_count + 1;   // completed line write-backs
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    a_reset_quiet: assert property (
        @(posedge clk) $rose(rst_n) |-> !mem_read && !mem_write && !proc_stall
    ) else begin
        other_errors = other_errors + 1;
        $display("memory request or stall active right after reset");
    end

    a_idle_no_stall: assert property (
        @(posedge clk) disable iff (!rst_n) !(proc_read || proc_write) |-> !proc_stall
    ) else begin
        value_errors = value_errors + 1;
        $display("Fail proc_stall: expected 0, got 1 with no request");
    end

    a_read_value: assert property (
        @(posedge clk) disable iff (!rst_n) proc_read && !proc_stall |-> proc_rdata == exp_rdata
    ) else begin
        value_errors = value_errors + 1;
        $display("Fail proc_rdata: addr %h expected %h, got %h", $sampled(proc_addr),
                 $sampled(exp_rdata), $sampled(proc_rdata));
    end

    a_first_cycle_hit: assert property (
        @(posedge clk) disable iff (!rst_n) expect_hit |-> !proc_stall
    ) else begin
        value_errors = value_errors + 1;
        $display("Fail proc_stall: expected 0, got 1 on a cached word");
    end

    a_first_cycle_miss: assert property (
        @(posedge clk) disable iff (!rst_n) expect_miss |-> proc_stall
    ) else begin
        value_errors = value_errors + 1;
        $display("Fail proc_stall: expected 1, got 0 on an uncached word");
    end

    a_mem_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(mem_read && mem_write)
    ) else begin
        other_errors = other_errors + 1;
        $display("memory read and write requested in the same cycle");
    end

    a_stall_bound: assert property (
        @(posedge clk) disable iff (!rst_n) stall_len < max_stall
    ) else begin
        other_errors = other_errors + 1;
        $display("a request stayed stalled for more than %0d cycles", max_stall);
    end

    // ------------------------------------------------------------------------
    // one request, held until a cycle with stall low
    // ------------------------------------------------------------------------
    task automatic run_access(input logic is_write, input word_addr_t addr, input word_t data,
                              input logic want_hit, input logic want_miss);
        @(negedge clk);
        proc_read   = !is_write;
        proc_write  = is_write;
        proc_addr   = addr;
        proc_wdata  = data;
        exp_rdata   = shadow[addr[win_bits-1:0]];
        expect_hit  = want_hit;     // only judged in the first cycle
        expect_miss = want_miss;
        @(negedge clk);
        expect_hit  = 1'b0;
        expect_miss = 1'b0;
        while (!access_done)
            @(negedge clk);
        if (is_write)
            shadow[addr[win_bits-1:0]] = data;
        proc_read  = 1'b0;
        proc_write = 1'b0;
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        integer     r;
        word_addr_t addr;
        clk          = 1'b0;
        rst_n        = 1'b0;
        proc_read    = 1'b0;
        proc_write   = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        exp_rdata    = '0;
        expect_hit   = 1'b0;
        expect_miss  = 1'b0;
        value_errors = 0;
        other_errors = 0;
        seed         = 32'h8106_f929;
        for (int k = 0; k < window_words; k++)
            shadow[k] = word_t'(k) ^ 32'h5A5A_0000;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);

        // cold read, then the same word again
        run_access(1'b0, 30'h025, '0, 1'b0, 1'b1);
        run_access(1'b0, 30'h025, '0, 1'b1, 1'b0);

        // write hit, write miss, read both back
        run_access(1'b1, 30'h025, 32'hCAFE_0001, 1'b1, 1'b0);
        run_access(1'b1, 30'h7C8, 32'hBEEF_0002, 1'b0, 1'b1);
        run_access(1'b0, 30'h025, '0, 1'b1, 1'b0);
        run_access(1'b0, 30'h7C8, '0, 1'b1, 1'b0);

        // three lines fighting over one set in both levels
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < 3; i++)
                run_access(1'b1, word_addr_t'(conflict_base + i * 128),
                           word_t'(32'hD000_0000 + round * 16 + i), 1'b0, 1'b0);
            for (int i = 0; i < 3; i++)
                run_access(1'b0, word_addr_t'(conflict_base + i * 128), '0, 1'b0, 1'b0);
        end
        a_wb_seen: assert (wb_count != 0) else begin
            other_errors = other_errors + 1;
            $display("no memory write-back seen during the eviction sequence");
        end

        // random mix over the whole window
        for (int n = 0; n < n_random; n++) begin
            r    = $random(seed);
            addr = word_addr_t'(r[win_bits-1:0]);
            run_access(r[16], addr, word_t'($random(seed)), 1'b0, 1'b0);
        end

        repeat (4) @(negedge clk);
        $display("errors: %0d value, %0d other, %0d line write-backs seen",
                 value_errors, other_errors, wb_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
hdl/cache_pkg.sv
hdl/cache_line_store.sv
hdl/cache_miss_fsm.sv
hdl/l1_cache.sv
hdl/l2_cache.sv
hdl/mem_hier_top.sv
verif/slow_mem_model.sv
verif/tb_mem_hier.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run tb_mem_hier with Verilator; the verdict comes from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mem_hier -f project.f -o tb_mem_hier_sim \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/tb_mem_hier_sim > sim.log 2>&1

grep -qx "TESTBENCH PASSED" sim.log \
    && echo "simulation passed, log in sim.log" \
    || { cat sim.log; echo "simulation failed, log in sim.log"; exit 1; }
